//--- sim.f
+incdir+.
ats1_pkg.sv
rom_loader.sv
prog_rom_bank.sv
gfx_store.sv
key_decoder.sv
control_mapper.sv
ats1_rom_ctrl_top.sv
tb_ats1_rom_ctrl.sv

//--- tb_ats1_rom_ctrl.sv
/*
 * Testbench for the System-1 ROM loading and control top level
 * Download, program ROM reads, graphics fetch, keys, coins and ADC mapping
 */
`timescale 1ns/1ps
`include "ats1_settings.svh"

module tb_ats1_rom_ctrl;

	// Run limit well above the length of the test sequence
	localparam int MAX_CYCLES = 4000;

	logic                        clk_sys;
	logic                        rst_n;
	logic                        dl_active;
	logic                        dl_wr;
	logic [7:0]                  dl_index;
	logic [`ATS1_DL_AW-1:0]      dl_addr;
	logic [`ATS1_BYTE_W-1:0]     dl_data;
	logic [10:0]                 ps2_key;
	logic [31:0]                 joy;
	logic [15:0]                 joy_analog;
	logic [2:0]                  adc_addr;
	logic [4:0]                  rom_n;
	logic                        ma18n;
	logic [`ATS1_MROM_AW:1]      madec;
	logic [`ATS1_GFX_AW-1:0]     vid_addr;
	logic [7:0]                  adc_data;
	logic [4:0]                  switches;
	logic [2:0]                  coin_n;
	logic [`ATS1_MROM_W-1:0]     mdata;
	logic [`ATS1_GFX_W-1:0]      vid_data;

	integer      seed;
	int          errors;
	int          errors_at_start;
	int          tests;
	int          fails;
	int          cycles;
	int          i;
	// Loaded words in the order ROM0 ROM1 ROM5 ROM7 SLAP
	logic [15:0] rom_word [0:4];
	logic [13:0] w_ofs;
	logic [9:0]  gw;
	logic [7:0]  gb [0:7];
	logic [63:0] exp64;
	// Held key model {up, down, left, right}
	logic [3:0]  kb_dir;
	logic        kb_start;
	logic        kb_jump;
	// Coin keys {aux, right, left}
	logic [2:0]  kb_coin;

	ats1_rom_ctrl_top i_dut
	(
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.ps2_key(ps2_key), .joy(joy), .joy_analog(joy_analog), .adc_addr(adc_addr),
		.rom_n(rom_n), .ma18n(ma18n), .madec(madec), .vid_addr(vid_addr),
		.adc_data(adc_data), .switches(switches), .coin_n(coin_n),
		.mdata(mdata), .vid_data(vid_data)
	);

	// ############################################################
	// Clock and run limit
	initial
	begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run stopped after %0d cycles", cycles);
		$display("Errors found");
		$finish;
	end

	// No ROM select gives zero data on the next cycle
	assert property (@(posedge clk_sys) disable iff (!rst_n) (&rom_n) |=> (mdata == 16'h0000))
	else
	begin
		$display("Mismatch at %0t: mdata got %0h, expected 0", $time, mdata);
		errors++;
	end

	// ############################################################
	// Helpers
	// Inputs change and outputs are sampled 1 ns after the edge
	task automatic step(input int n);
		begin
			repeat (n) @(posedge clk_sys);
			#1;
		end
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		begin
			assert (got === exp)
			else
			begin
				$display("Mismatch at %0t: %s got %0h, expected %0h", $time, name, got, exp);
				errors++;
			end
		end
	endtask

	task automatic end_test(input string name);
		begin
			tests++;
			if (errors != errors_at_start)
				fails++;
			$display("Test %0d %s: %0d errors", tests, name, errors - errors_at_start);
			errors_at_start = errors;
		end
	endtask

	// One download byte with the strobe held for a single cycle
	task automatic dl_byte(input logic [7:0] idx, input logic [24:0] addr,
		input logic [7:0] data);
		begin
			step(1);
			dl_active = 1'b1;
			dl_wr     = 1'b1;
			dl_index  = idx;
			dl_addr   = addr;
			dl_data   = data;
		end
	endtask

	task automatic dl_stop;
		begin
			step(1);
			dl_wr     = 1'b0;
			dl_active = 1'b0;
		end
	endtask

	// Even byte first as the high half
	task automatic load_word(input logic [24:0] base, input logic [15:0] pair);
		begin
			dl_byte(8'd0, base + {w_ofs, 1'b0}, pair[15:8]);
			dl_byte(8'd0, base + {w_ofs, 1'b1}, pair[7:0]);
		end
	endtask

	// Data one cycle after select
	task automatic rom_read(input logic [4:0] rn, input logic m18, input logic [15:0] exp);
		begin
			step(1);
			rom_n = rn;
			ma18n = m18;
			madec = {1'b0, w_ofs};
			step(1);
			check_val("mdata", mdata, exp);
		end
	endtask

	// Game byte on index 1 with mapper output one cycle later
	task automatic set_game(input logic [7:0] code);
		begin
			dl_byte(8'd1, '0, code);
			dl_stop;
			step(1);
		end
	endtask

	// Cabinet switches and coin lines from the held controls
	function automatic logic [4:0] exp_sw(input logic pp);
		logic a0;
		logic a1;
		begin
			a0 = kb_jump | joy[4];
			a1 = kb_start | joy[5];
			exp_sw = pp ? {2'b11, ~a0, 1'b1, ~a1} : {3'b111, ~a0, ~a1};
		end
	endfunction

	function automatic logic [2:0] exp_coin();
		begin
			exp_coin = {~kb_coin[2], ~kb_coin[1], ~(kb_coin[0] | joy[8])};
		end
	endfunction

	// On/off ADC level for the direction switches
	function automatic logic [7:0] dir_adc(input logic pp, input logic [2:0] ch,
		input logic [3:0] d4);
		logic [7:0] chans;
		begin
			chans = pp ? {4'b0000, d4} : {3'b000, d4, 1'b0};
			dir_adc = chans[ch] ? 8'hFF : 8'h80;
		end
	endfunction

	task automatic key_check(input logic [8:0] code, input logic press, input logic pp);
		begin
			step(1);
			// Toggle bit marks a new event
			ps2_key = {~ps2_key[10], press, code};
			case (code)
				`ATS1_KEY_UP:       kb_dir[3] = press;
				`ATS1_KEY_DOWN:     kb_dir[2] = press;
				`ATS1_KEY_LEFT:     kb_dir[1] = press;
				`ATS1_KEY_RIGHT:    kb_dir[0] = press;
				`ATS1_KEY_START:    kb_start = press;
				`ATS1_KEY_JUMP:     kb_jump = press;
				`ATS1_KEY_COIN_L:   kb_coin[0] = press;
				`ATS1_KEY_COIN_R:   kb_coin[1] = press;
				`ATS1_KEY_COIN_AUX: kb_coin[2] = press;
				default: ;
			endcase
			// Decoder then mapper register
			step(2);
			check_val("switches", switches, exp_sw(pp));
			check_val("coin_n", coin_n, exp_coin());
		end
	endtask

	task automatic adc_expect(input logic [2:0] ch, input logic [7:0] exp);
		begin
			step(1);
			adc_addr = ch;
			step(1);
			check_val("adc_data", adc_data, exp);
		end
	endtask

	// ############################################################
	// Test sequence
	initial
	begin
		seed = 32'hcae228f6;
		errors = 0;
		errors_at_start = 0;
		tests = 0;
		fails = 0;
		kb_dir = '0;
		kb_start = 1'b0;
		kb_jump = 1'b0;
		kb_coin = '0;
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		ps2_key = '0;
		joy = '0;
		joy_analog = '0;
		adc_addr = '0;
		rom_n = 5'b11111;
		ma18n = 1'b1;
		madec = '0;
		vid_addr = '0;
		step(2);
		rst_n = 1'b1;

		// Reset values with Indy on channel 0
		check_val("switches", switches, 5'b11111);
		check_val("coin_n", coin_n, 3'b111);
		check_val("adc_data", adc_data, 8'h80);
		check_val("mdata", mdata, 16'h0000);
		end_test("reset values");

		// Same word offset in every block
		w_ofs = $random(seed);
		for (i = 0; i < 5; i++)
			rom_word[i] = $random(seed);
		load_word(`ATS1_RGN_ROM0, rom_word[0]);
		load_word(`ATS1_RGN_ROM1, rom_word[1]);
		load_word(`ATS1_RGN_ROM5, rom_word[2]);
		load_word(`ATS1_RGN_ROM7, rom_word[3]);
		load_word(`ATS1_RGN_SLAP, rom_word[4]);
		dl_stop;
		rom_read(5'b11110, 1'b1, rom_word[0]);
		rom_read(5'b11101, 1'b1, rom_word[1]);
		rom_read(5'b11101, 1'b0, rom_word[2]);
		rom_read(5'b10111, 1'b1, rom_word[3]);
		rom_read(5'b10111, 1'b0, rom_word[3]);
		rom_read(5'b01111, 1'b1, rom_word[4]);
		// Priority among several active selects
		rom_read(5'b00000, 1'b1, rom_word[0]);
		rom_read(5'b01101, 1'b0, rom_word[2]);
		rom_read(5'b11111, 1'b1, 16'h0000);
		// Other index leaves ROM untouched
		dl_byte(8'd2, `ATS1_RGN_ROM0 + {w_ofs, 1'b0}, ~rom_word[0][15:8]);
		dl_byte(8'd2, `ATS1_RGN_ROM0 + {w_ofs, 1'b1}, ~rom_word[0][7:0]);
		dl_stop;
		rom_read(5'b11110, 1'b1, rom_word[0]);
		end_test("program ROM load and read");

		// Graphics word with upper address bits aliased away
		gw = $random(seed);
		exp64 = '0;
		for (i = 0; i < 8; i++)
		begin
			gb[i] = $random(seed);
			exp64 = {exp64[55:0], gb[i]};
			dl_byte(8'd0, 25'h0380000 | {gw, 3'b000} | i[2:0], gb[i]);
		end
		dl_stop;
		vid_addr = gw;
		step(1);
		check_val("vid_data", vid_data, exp64);
		end_test("graphics store");

		// Buttons and coins under Indy then Peterpak
		set_game(ats1_pkg::GAME_INDY);
		key_check(`ATS1_KEY_START, 1'b1, 1'b0);
		key_check(`ATS1_KEY_JUMP, 1'b1, 1'b0);
		key_check(`ATS1_KEY_START, 1'b0, 1'b0);
		key_check(`ATS1_KEY_COIN_L, 1'b1, 1'b0);
		key_check(`ATS1_KEY_COIN_R, 1'b1, 1'b0);
		key_check(`ATS1_KEY_COIN_AUX, 1'b1, 1'b0);
		key_check(`ATS1_KEY_COIN_L, 1'b0, 1'b0);
		key_check(`ATS1_KEY_COIN_R, 1'b0, 1'b0);
		key_check(`ATS1_KEY_COIN_AUX, 1'b0, 1'b0);
		joy[8] = 1'b1;
		step(1);
		check_val("coin_n", coin_n, exp_coin());
		joy[8] = 1'b0;
		set_game(ats1_pkg::GAME_PETERPAK);
		check_val("switches", switches, exp_sw(1'b1));
		key_check(`ATS1_KEY_JUMP, 1'b0, 1'b1);
		key_check(`ATS1_KEY_START, 1'b1, 1'b1);
		joy[4] = 1'b1;
		step(1);
		check_val("switches", switches, exp_sw(1'b1));
		joy[4] = 1'b0;
		key_check(`ATS1_KEY_START, 1'b0, 1'b1);
		end_test("keyboard and coins");

		// Direction switches on ADC channels
		set_game(ats1_pkg::GAME_INDY);
		key_check(`ATS1_KEY_UP, 1'b1, 1'b0);
		key_check(`ATS1_KEY_LEFT, 1'b1, 1'b0);
		joy[0] = 1'b1;
		for (i = 0; i < 8; i++)
			adc_expect(i[2:0], dir_adc(1'b0, i[2:0], kb_dir | joy[3:0]));
		set_game(ats1_pkg::GAME_PETERPAK);
		for (i = 0; i < 8; i++)
			adc_expect(i[2:0], dir_adc(1'b1, i[2:0], kb_dir | joy[3:0]));
		joy[0] = 1'b0;
		// Roadrunner stick with X inverted
		set_game(ats1_pkg::GAME_ROADRUNNER);
		joy_analog = $random(seed);
		adc_expect(3'd0, joy_analog[7:0] ^ 8'h7F);
		adc_expect(3'd7, joy_analog[15:8] ^ 8'h80);
		adc_expect(3'd3, 8'h80);
		// Roadblaster throttle from forward stick only
		set_game(ats1_pkg::GAME_ROADBLAST_A);
		joy_analog = $random(seed);
		joy_analog[15] = 1'b1;
		adc_expect(3'd3, {joy_analog[14:8], 1'b1} ^ 8'hFF);
		adc_expect(3'd2, 8'h00);
		joy_analog[15] = 1'b0;
		adc_expect(3'd3, 8'h00);
		set_game(ats1_pkg::GAME_MARBLE);
		adc_expect(3'd4, 8'h80);
		adc_expect(3'd0, 8'h80);
		end_test("ADC mapping");

		$display("Summary: %0d tests, %0d failed, %0d errors", tests, fails, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- ats1_rom_ctrl_top.sv
/*
 * System-1 ROM loading and control top level
 * Loader, program ROM bank, graphics store, keyboard and mapper
 */
`timescale 1ns/1ps
`include "ats1_settings.svh"

module ats1_rom_ctrl_top
(
	input  logic                          clk_sys,
	input  logic                          rst_n,
	// Download stream
	input  logic                          dl_active,
	input  logic                          dl_wr,
	input  logic [7:0]                    dl_index,
	input  logic [`ATS1_DL_AW-1:0]        dl_addr,
	input  logic [`ATS1_BYTE_W-1:0]       dl_data,
	// Player controls
	input  logic [10:0]                   ps2_key,
	input  logic [31:0]                   joy,
	input  logic [15:0]                   joy_analog,
	input  logic [2:0]                    adc_addr,
	// CPU ROM side
	input  logic [4:0]                    rom_n,
	input  logic                          ma18n,
	input  logic [`ATS1_MROM_AW:1]        madec,
	// Video fetch
	input  logic [`ATS1_GFX_AW-1:0]       vid_addr,
	output logic [7:0]                    adc_data,
	output logic [4:0]                    switches,
	output logic [2:0]                    coin_n,
	output logic [`ATS1_MROM_W-1:0]       mdata,
	output logic [`ATS1_GFX_W-1:0]        vid_data
);

	ats1_pkg::dl_region_t        dl_region;
	logic                        prog_wr;
	logic                        gfx_wr;
	logic [`ATS1_DL_AW-1:0]      wr_addr;
	logic [`ATS1_MROM_W-1:0]     word16;
	logic [`ATS1_GFX_W-1:0]      word64;
	logic                        cfg_wr;
	logic [`ATS1_BYTE_W-1:0]     cfg_data;
	logic [7:0]                  kbd;
	logic [2:0]                  coin_keys;

	// ############################################################
	// Download side
	rom_loader i_rom_loader
	(
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.dl_region(dl_region), .prog_wr(prog_wr), .gfx_wr(gfx_wr),
		.wr_addr(wr_addr), .word16(word16), .word64(word64),
		.cfg_wr(cfg_wr), .cfg_data(cfg_data)
	);

	prog_rom_bank i_prog_rom_bank
	(
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_region(dl_region), .prog_wr(prog_wr), .wr_addr(wr_addr), .word16(word16),
		.rom_n(rom_n), .ma18n(ma18n), .madec(madec), .mdata(mdata)
	);

	// Video side
	gfx_store i_gfx_store
	(
		.clk_sys(clk_sys), .dl_active(dl_active), .gfx_wr(gfx_wr),
		.wr_addr(wr_addr), .word64(word64),
		.vid_addr(vid_addr), .vid_data(vid_data)
	);

	// ############################################################
	// Controls
	key_decoder i_key_decoder
	(
		.clk_sys(clk_sys), .rst_n(rst_n), .ps2_key(ps2_key),
		.kbd(kbd), .coin_keys(coin_keys)
	);

	control_mapper i_control_mapper
	(
		.clk_sys(clk_sys), .rst_n(rst_n),
		.cfg_wr(cfg_wr), .cfg_data(cfg_data),
		.kbd(kbd), .coin_keys(coin_keys),
		.joy(joy), .joy_analog(joy_analog), .adc_addr(adc_addr),
		.switches(switches), .adc_data(adc_data), .coin_n(coin_n)
	);

endmodule

//--- control_mapper.sv
/*
 * Per-game control mapper
 * Game type register, cabinet switches, ADC channel data and coin lines
 */
`timescale 1ns/1ps
`include "ats1_settings.svh"

module control_mapper
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        cfg_wr,
	input  logic [7:0]  cfg_data,
	input  logic [7:0]  kbd,
	input  logic [2:0]  coin_keys,
	input  logic [31:0] joy,
	input  logic [15:0] joy_analog,
	input  logic [2:0]  adc_addr,
	output logic [4:0]  switches,
	output logic [7:0]  adc_data,
	output logic [2:0]  coin_n
);

	ats1_pkg::game_t game_q;
	logic [3:0]      dir4;
	logic            a0;
	logic            a1;
	logic [7:0]      indy_vec;
	logic [7:0]      pp_vec;

	// Keyboard and joystick merged
	assign dir4 = kbd[7:4] | joy[3:0];
	assign a0   = kbd[0] | joy[4];
	assign a1   = kbd[1] | joy[5];

	// Indy channels shifted up by one
	assign indy_vec = {3'b000, dir4, 1'b0};
	assign pp_vec   = {4'b0000, dir4};

	// Game type from download index 1
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			game_q <= ats1_pkg::GAME_INDY;
		else if (cfg_wr)
			game_q <= ats1_pkg::game_t'(cfg_data);
	end

	// ############################################################
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			switches <= 5'b11111;
			adc_data <= `ATS1_ADC_CENTER;
			coin_n   <= 3'b111;
		end
		else
		begin
			// Coins active low, joystick adds left coin
			coin_n <= {~coin_keys[2], ~coin_keys[1], ~(coin_keys[0] | joy[8])};

			// Peterpak has jump on SW3
			if (game_q == ats1_pkg::GAME_PETERPAK)
				switches <= {2'b11, ~a0, 1'b1, ~a1};
			else
				switches <= {3'b111, ~a0, ~a1};

			case (game_q)
				ats1_pkg::GAME_MARBLE: adc_data <= `ATS1_ADC_CENTER;
				// On/off direction switches on ADC channels
				ats1_pkg::GAME_INDY:
					adc_data <= indy_vec[adc_addr] ? `ATS1_ADC_FULL : `ATS1_ADC_CENTER;
				ats1_pkg::GAME_PETERPAK:
					adc_data <= pp_vec[adc_addr] ? `ATS1_ADC_FULL : `ATS1_ADC_CENTER;
				// Signed stick to unsigned, X inverted
				ats1_pkg::GAME_ROADRUNNER:
				begin
					if (adc_addr == 3'd0)
						adc_data <= joy_analog[7:0] ^ 8'h7F;
					else if (adc_addr == 3'd7)
						adc_data <= joy_analog[15:8] ^ 8'h80;
					else
						adc_data <= `ATS1_ADC_CENTER;
				end
				// Throttle from negative Y only, doubled
				ats1_pkg::GAME_ROADBLAST_A, ats1_pkg::GAME_ROADBLAST_B:
				begin
					if (adc_addr == 3'd3 && joy_analog[15])
						adc_data <= {joy_analog[14:8], 1'b1} ^ 8'hFF;
					else
						adc_data <= 8'h00;
				end
				default: ;  // unknown type holds
			endcase
		end
	end

endmodule

//--- key_decoder.sv
/*
 * Keyboard event decoder
 * Holds player-1 direction, button and coin key levels
 */
`timescale 1ns/1ps
`include "ats1_settings.svh"

module key_decoder
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	output logic [7:0]  kbd,
	output logic [2:0]  coin_keys
);

	logic toggle_q;
	logic pressed;

	// Bit 9 is make or break, bit 10 flips per event
	assign pressed = ps2_key[9];

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			toggle_q  <= 1'b0;
			kbd       <= '0;
			coin_keys <= '0;
		end
		else
		begin
			toggle_q <= ps2_key[10];
			// New event
			if (toggle_q != ps2_key[10])
			begin
				case (ps2_key[8:0])
					`ATS1_KEY_UP:       kbd[7] <= pressed;
					`ATS1_KEY_DOWN:     kbd[6] <= pressed;
					`ATS1_KEY_LEFT:     kbd[5] <= pressed;
					`ATS1_KEY_RIGHT:    kbd[4] <= pressed;
					`ATS1_KEY_START:    kbd[1] <= pressed;
					`ATS1_KEY_JUMP:     kbd[0] <= pressed;
					// Coins as aux, right, left
					`ATS1_KEY_COIN_L:   coin_keys[0] <= pressed;
					`ATS1_KEY_COIN_R:   coin_keys[1] <= pressed;
					`ATS1_KEY_COIN_AUX: coin_keys[2] <= pressed;
					default: ;
				endcase
			end
		end
	end

endmodule

//--- gfx_store.sv
/*
 * Graphics word store
 * Loader owns the port during download, video fetch otherwise
 */
`timescale 1ns/1ps
`include "ats1_settings.svh"

module gfx_store
(
	input  logic                          clk_sys,
	input  logic                          dl_active,
	input  logic                          gfx_wr,
	input  logic [`ATS1_DL_AW-1:0]        wr_addr,
	input  logic [`ATS1_GFX_W-1:0]        word64,
	input  logic [`ATS1_GFX_AW-1:0]       vid_addr,
	output logic [`ATS1_GFX_W-1:0]        vid_data
);

	localparam int DEPTH = 1 << `ATS1_GFX_AW;

	logic [`ATS1_GFX_W-1:0]  mem [0:DEPTH-1];
	logic [`ATS1_GFX_AW-1:0] addr;

	// Port owner, loader first
	// Word address from byte address, upper bits alias
	assign addr = dl_active ? wr_addr[`ATS1_GFX_AW+2:3] : vid_addr;

	// Single port, read held while loading
	always_ff @(posedge clk_sys)
	begin
		if (dl_active)
		begin
			if (gfx_wr)
				mem[addr] <= word64;
		end
		else
		begin
			vid_data <= mem[addr];
		end
	end

endmodule

//--- prog_rom_bank.sv
/*
 * Program ROM bank
 * Seven 16-bit blocks loaded from the download stream and read
 * by the CPU through the ROM selects, block 3 aliased onto block 7
 */
`timescale 1ns/1ps
`include "ats1_settings.svh"

module prog_rom_bank
(
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  ats1_pkg::dl_region_t          dl_region,
	input  logic                          prog_wr,
	input  logic [`ATS1_DL_AW-1:0]        wr_addr,
	input  logic [`ATS1_MROM_W-1:0]       word16,
	input  logic [4:0]                    rom_n,
	input  logic                          ma18n,
	input  logic [`ATS1_MROM_AW:1]        madec,
	output logic [`ATS1_MROM_W-1:0]       mdata
);

	localparam int BIG_DEPTH = 1 << `ATS1_MROM_AW;
	localparam int SMALL_DEPTH = 1 << (`ATS1_MROM_AW - 1);

	// Large blocks 1, 2, 5, 6, 7 at index 0..4
	logic [`ATS1_MROM_W-1:0] big_mem [0:4][0:BIG_DEPTH-1];
	// Small blocks 0 and slapstic at index 0..1
	logic [`ATS1_MROM_W-1:0] small_mem [0:1][0:SMALL_DEPTH-1];

	logic [`ATS1_MROM_W-1:0] big_q [0:4];
	logic [`ATS1_MROM_W-1:0] small_q [0:1];
	logic [2:0]              big_sel;
	logic                    big_we;
	logic                    small_sel;
	logic                    small_we;
	logic [4:0]              rom_n_q;
	logic                    ma18n_q;

	// Region to block index
	always_comb
	begin
		big_sel   = 3'd0;
		big_we    = 1'b0;
		small_sel = 1'b0;
		small_we  = 1'b0;
		case (dl_region)
			ats1_pkg::RGN_ROM0: small_we = prog_wr;
			ats1_pkg::RGN_SLAP:
			begin
				small_sel = 1'b1;
				small_we  = prog_wr;
			end
			ats1_pkg::RGN_ROM1: big_we = prog_wr;
			ats1_pkg::RGN_ROM2:
			begin
				big_sel = 3'd1;
				big_we  = prog_wr;
			end
			ats1_pkg::RGN_ROM5:
			begin
				big_sel = 3'd2;
				big_we  = prog_wr;
			end
			ats1_pkg::RGN_ROM6:
			begin
				big_sel = 3'd3;
				big_we  = prog_wr;
			end
			ats1_pkg::RGN_ROM7:
			begin
				big_sel = 3'd4;
				big_we  = prog_wr;
			end
			default: ;
		endcase
	end

	// ############################################################
	// Loader writes and pipelined CPU reads, one per cycle
	always_ff @(posedge clk_sys)
	begin
		if (big_we)
			big_mem[big_sel][wr_addr[`ATS1_MROM_AW:1]] <= word16;
		if (small_we)
			small_mem[small_sel][wr_addr[`ATS1_MROM_AW-1:1]] <= word16;
		for (int b = 0; b < 5; b++)
			big_q[b] <= big_mem[b][madec[`ATS1_MROM_AW:1]];
		for (int s = 0; s < 2; s++)
			small_q[s] <= small_mem[s][madec[`ATS1_MROM_AW-1:1]];
	end

	// Select follows the read by one cycle, idle after reset
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rom_n_q <= 5'b11111;
			ma18n_q <= 1'b1;
		end
		else
		begin
			rom_n_q <= rom_n;
			ma18n_q <= ma18n;
		end
	end

	// First match wins, rom_n active low
	always_comb
	begin
		if (ma18n_q && !rom_n_q[0])
			mdata = small_q[0];
		else if (ma18n_q && !rom_n_q[1])
			mdata = big_q[0];
		else if (ma18n_q && !rom_n_q[2])
			mdata = big_q[1];
		else if (ma18n_q && !rom_n_q[3])
			mdata = big_q[4];  // block 3 alias
		else if (!ma18n_q && !rom_n_q[1])
			mdata = big_q[2];
		else if (!ma18n_q && !rom_n_q[2])
			mdata = big_q[3];
		else if (!ma18n_q && !rom_n_q[3])
			mdata = big_q[4];
		else if (!rom_n_q[4])
			mdata = small_q[1];
		else
			mdata = '0;
	end

endmodule

//--- rom_loader.sv
/*
 * Download stream loader
 * Accumulates index-0 bytes into words, decodes the target region
 * and raises program, graphics and config write strobes
 */
`timescale 1ns/1ps
`include "ats1_settings.svh"

module rom_loader
(
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          dl_active,
	input  logic                          dl_wr,
	input  logic [7:0]                    dl_index,
	input  logic [`ATS1_DL_AW-1:0]        dl_addr,
	input  logic [`ATS1_BYTE_W-1:0]       dl_data,
	output ats1_pkg::dl_region_t          dl_region,
	output logic                          prog_wr,
	output logic                          gfx_wr,
	output logic [`ATS1_DL_AW-1:0]        wr_addr,
	output logic [`ATS1_MROM_W-1:0]       word16,
	output logic [`ATS1_GFX_W-1:0]        word64,
	output logic                          cfg_wr,
	output logic [`ATS1_BYTE_W-1:0]       cfg_data
);

	// Region masks, 32 KB and 64 KB windows
	localparam logic [`ATS1_DL_AW-1:0] MASK_32K = 25'h1FF8000;
	localparam logic [`ATS1_DL_AW-1:0] MASK_64K = 25'h1FF0000;

	// Seven previous bytes, newest in the low byte
	logic [`ATS1_GFX_W-`ATS1_BYTE_W-1:0] acc;
	logic                                rom_byte;
	logic                                prog_rgn;

	// Byte for the ROM images
	assign rom_byte = dl_wr & dl_active & (dl_index == 8'd0);

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			acc <= '0;
		else if (rom_byte)
			acc <= {acc[`ATS1_GFX_W-2*`ATS1_BYTE_W-1:0], dl_data};
	end

	// ############################################################
	// Region decode, graphics sits below the first program block
	always_comb
	begin
		dl_region = ats1_pkg::RGN_NONE;
		if (!dl_active || dl_index != 8'd0)
			dl_region = ats1_pkg::RGN_NONE;
		else if (dl_addr < `ATS1_RGN_ROM0)
			dl_region = ats1_pkg::RGN_GFX;
		else if ((dl_addr & MASK_32K) == `ATS1_RGN_ROM0)
			dl_region = ats1_pkg::RGN_ROM0;
		else if ((dl_addr & MASK_64K) == `ATS1_RGN_ROM1)
			dl_region = ats1_pkg::RGN_ROM1;
		else if ((dl_addr & MASK_64K) == `ATS1_RGN_ROM2)
			dl_region = ats1_pkg::RGN_ROM2;
		else if ((dl_addr & MASK_64K) == `ATS1_RGN_ROM5)
			dl_region = ats1_pkg::RGN_ROM5;
		else if ((dl_addr & MASK_64K) == `ATS1_RGN_ROM6)
			dl_region = ats1_pkg::RGN_ROM6;
		else if ((dl_addr & MASK_64K) == `ATS1_RGN_ROM7)
			dl_region = ats1_pkg::RGN_ROM7;
		else if ((dl_addr & MASK_32K) == `ATS1_RGN_SLAP)
			dl_region = ats1_pkg::RGN_SLAP;
	end

	// Any of the 16-bit program blocks
	assign prog_rgn = (dl_region != ats1_pkg::RGN_NONE) && (dl_region != ats1_pkg::RGN_GFX);

	// Program word completes on the odd byte
	assign prog_wr = rom_byte & prog_rgn & dl_addr[0];
	// Graphics word completes on byte 7 of 8
	assign gfx_wr  = rom_byte & (dl_region == ats1_pkg::RGN_GFX) & (dl_addr[2:0] == 3'd7);

	assign wr_addr = dl_addr;
	assign word16  = {acc[`ATS1_BYTE_W-1:0], dl_data};
	// First byte lands in the MSB
	assign word64  = {acc, dl_data};

	// Game type byte
	assign cfg_wr   = dl_wr & (dl_index == 8'd1);
	assign cfg_data = dl_data;

endmodule

//--- ats1_pkg.sv
/*
 * System-1 shared types
 * Game type codes and decoded download regions
 */
package ats1_pkg;

	// Game type as written on download index 1
	// Value matches the slapstic chip number
	typedef enum logic [7:0]
	{
		GAME_MARBLE      = 8'd103,
		GAME_INDY        = 8'd105,
		GAME_PETERPAK    = 8'd107,
		GAME_ROADRUNNER  = 8'd108,
		GAME_ROADBLAST_A = 8'd109,
		GAME_ROADBLAST_B = 8'd110
	} game_t;

	// Target of an index-0 download byte
	typedef enum logic [3:0]
	{
		RGN_NONE,
		RGN_GFX,
		RGN_ROM0,
		RGN_ROM1,
		RGN_ROM2,
		RGN_ROM5,
		RGN_ROM6,
		RGN_ROM7,
		RGN_SLAP
	} dl_region_t;

endpackage

//--- ats1_settings.svh
/*
 * System-1 ROM and control block settings
 * Widths, depths, download map, keycodes and ADC levels
 */
`ifndef ATS1_SETTINGS_SVH
`define ATS1_SETTINGS_SVH

// Download stream
`define ATS1_DL_AW 25
`define ATS1_BYTE_W 8

// Program ROM, small blocks use one address bit fewer
`define ATS1_MROM_W 16
`define ATS1_MROM_AW 15

// On-chip graphics store, upper download bits alias
`define ATS1_GFX_W 64
`define ATS1_GFX_AW 10

// Download map region bases
`define ATS1_RGN_ROM0 25'h0400000
`define ATS1_RGN_ROM1 25'h0410000
`define ATS1_RGN_ROM2 25'h0420000
`define ATS1_RGN_ROM5 25'h0450000
`define ATS1_RGN_ROM6 25'h0460000
`define ATS1_RGN_ROM7 25'h0470000
`define ATS1_RGN_SLAP 25'h0480000

// Player 1 keycodes, extended flag in bit 8
`define ATS1_KEY_UP 9'h175
`define ATS1_KEY_DOWN 9'h172
`define ATS1_KEY_LEFT 9'h16B
`define ATS1_KEY_RIGHT 9'h174
`define ATS1_KEY_START 9'h014
`define ATS1_KEY_JUMP 9'h011
`define ATS1_KEY_COIN_L 9'h02E
`define ATS1_KEY_COIN_R 9'h036
`define ATS1_KEY_COIN_AUX 9'h03D

// ADC levels
`define ATS1_ADC_CENTER 8'h80
`define ATS1_ADC_FULL 8'hFF

`endif
